// ==== design/lfb_alloc.sv ====
`default_nettype none

module lfb_alloc #(
  parameter int NUM_ENTRIES = 2
) (
  input  wire                   lfb_data_entry_clk,
  input  wire                   cpurst_b,
  input  wire                   r_vld,
  input  wire lfb_bus_pkg::id_t r_id,
  input  wire lfb_geom_pkg::beat_t r_data,
  input  wire                   r_last,
  input  wire                   r_err,
  input  wire lfb_geom_pkg::slot_t r_ptr,
  output logic                  r_ready,
  lfb_fill_if.alloc             fill
);

  logic [NUM_ENTRIES-1:0] hit_vec;
  logic [NUM_ENTRIES-1:0] free_vec;
  logic                   any_hit;
  logic                   any_free;

  // ==============================
  // id match
  // ==============================
  // only entries still collecting beats can take an interleaved beat
  always_comb
  begin
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      hit_vec[i] = fill.filling[i] && (fill.entry_id[i] == r_id);
    end
  end

  // lowest idle entry
  always_comb
  begin
    logic found;
    found    = 1'b0;
    free_vec = '0;
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      if (!fill.busy[i] && !found)
      begin
        free_vec[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign any_hit  = |hit_vec;
  assign any_free = |free_vec;

  // a new id waits while every entry is taken
  assign r_ready = any_hit || any_free;

  // ==============================
  // beat forwarding
  // ==============================
  assign fill.beat_vld  = r_vld && r_ready;
  assign fill.beat_id   = r_id;
  assign fill.beat_data = r_data;
  assign fill.beat_last = r_last;
  assign fill.beat_err  = r_err;
  assign fill.beat_ptr  = r_ptr;
  assign fill.hit       = hit_vec;
  assign fill.create    = any_hit ? '0 : free_vec;

  // an id never lives in two entries that are still filling
  a_hit_onehot: assert property (
    @(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    r_vld |-> $onehot0(hit_vec)
  );

endmodule

`default_nettype wire

// ==== design/lfb_bus_pkg.sv ====
`default_nettype none

package lfb_bus_pkg;

  // ==============================
  // read response side
  // ==============================
  // transaction id, also used as the line index in the data array
  typedef logic [2:0] id_t;

  // ==============================
  // wishbone write side
  // ==============================
  // word address is {id, slot}
  typedef logic [4:0] wb_adr_t;

endpackage

`default_nettype wire

// ==== design/lfb_data_entry.sv ====
`default_nettype none

module lfb_data_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  wire      lfb_data_entry_clk,
  input  wire      cpurst_b,
  input  wire      dcache_en,
  lfb_fill_if.entry fill,
  lfb_lf_if.entry   lf
);
  import lfb_geom_pkg::*;
  import lfb_bus_pkg::*;

  localparam int    BW       = $bits(beat_t);
  localparam slot_t LAST_CNT = slot_t'(BEATS_PER_LINE - 1);
  localparam slot_t PRE_LAST = slot_t'(BEATS_PER_LINE - 2);

  entry_state_t state_q;
  id_t          id_q;
  slot_t        ptr_q;
  slot_t        cnt_q;
  logic         err_q;
  line_t        line_q;

  logic         take_create;
  logic         take_hit;
  logic         err_all;
  logic         line_full;
  slot_t        wr_slot;

  // ==============================
  // beat acceptance
  // ==============================
  assign take_create = fill.beat_vld && fill.create[ENTRY_IDX];
  assign take_hit    = fill.beat_vld && fill.hit[ENTRY_IDX];

  // first beat goes to the critical word, the rest follow in turn
  assign wr_slot   = take_create ? fill.beat_ptr : ptr_q;
  assign err_all   = err_q || fill.beat_err;
  assign line_full = take_hit && (cnt_q == PRE_LAST);

  // ==============================
  // state machine
  // ==============================
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      state_q <= st_idle;
    end
    else
    begin
      case (state_q)
        st_idle:
        begin
          // single beat read never asks for a linefill
          if (take_create && !fill.beat_last)
            state_q <= st_fill;
        end
        st_fill:
        begin
          if (take_hit && fill.beat_last)
          begin
            if (line_full && !err_all && dcache_en)
              state_q <= st_req;
            else
              state_q <= st_idle;
          end
        end
        st_req:
        begin
          if (lf.grant[ENTRY_IDX])
            state_q <= st_write;
        end
        st_write:
        begin
          if (lf.done[ENTRY_IDX])
            state_q <= st_idle;
        end
        default:
        begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // id, rotating pointer, beat count, sticky error
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      id_q  <= '0;
      ptr_q <= '0;
      cnt_q <= '0;
      err_q <= 1'b0;
    end
    else if (take_create)
    begin
      id_q  <= fill.beat_id;
      ptr_q <= fill.beat_ptr + 2'd1;
      cnt_q <= '0;
      err_q <= fill.beat_err;
    end
    else if (take_hit)
    begin
      ptr_q <= ptr_q + 2'd1;
      cnt_q <= cnt_q + 2'd1;
      err_q <= err_all;
    end
  end

  // line storage
  always_ff @(posedge lfb_data_entry_clk)
  begin
    if (take_create || take_hit)
      line_q[wr_slot*BW +: BW] <= fill.beat_data;
  end

  // ==============================
  // outputs
  // ==============================
  assign fill.busy[ENTRY_IDX]     = (state_q != st_idle);
  assign fill.filling[ENTRY_IDX]  = (state_q == st_fill);
  assign fill.entry_id[ENTRY_IDX] = id_q;

  assign lf.req[ENTRY_IDX]     = (state_q == st_req);
  assign lf.line[ENTRY_IDX]    = line_q;
  assign lf.line_id[ENTRY_IDX] = id_q;

  // the bus closes every burst by the fourth beat
  a_no_fifth_beat: assert property (
    @(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    take_hit |-> (cnt_q != LAST_CNT)
  );

endmodule

`default_nettype wire

// ==== design/lfb_geom_pkg.sv ====
`default_nettype none

package lfb_geom_pkg;

  // ==============================
  // line geometry
  // ==============================
  localparam int BEATS_PER_LINE = 4;

  // one bus beat and one full cache line
  typedef logic [31:0] beat_t;
  typedef logic [BEATS_PER_LINE*32-1:0] line_t;

  // beat index inside a line
  typedef logic [$clog2(BEATS_PER_LINE)-1:0] slot_t;

  // fill entry life cycle
  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_req,
    st_write
  } entry_state_t;

endpackage

`default_nettype wire

// ==== design/lfb_if.sv ====
`default_nettype none

// beat path from the allocator into the fill entries
interface lfb_fill_if #(
  parameter int NUM_ENTRIES = 2
);
  import lfb_geom_pkg::*;
  import lfb_bus_pkg::*;

  logic                   beat_vld;
  id_t                    beat_id;
  beat_t                  beat_data;
  logic                   beat_last;
  logic                   beat_err;
  slot_t                  beat_ptr;
  logic [NUM_ENTRIES-1:0] create;
  logic [NUM_ENTRIES-1:0] hit;

  // entry status, one element per entry
  logic [NUM_ENTRIES-1:0] busy;
  logic [NUM_ENTRIES-1:0] filling;
  id_t                    entry_id [NUM_ENTRIES];

  modport alloc (
    output beat_vld, beat_id, beat_data, beat_last, beat_err, beat_ptr,
    output create, hit,
    input  busy, filling, entry_id
  );

  modport entry (
    input  beat_vld, beat_id, beat_data, beat_last, beat_err, beat_ptr,
    input  create, hit,
    output busy, filling, entry_id
  );
endinterface

// linefill request and grant between the entries and the arbiter
interface lfb_lf_if #(
  parameter int NUM_ENTRIES = 2
);
  import lfb_geom_pkg::*;
  import lfb_bus_pkg::*;

  logic [NUM_ENTRIES-1:0] req;
  line_t                  line [NUM_ENTRIES];
  id_t                    line_id [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] grant;
  logic [NUM_ENTRIES-1:0] done;

  modport entry (output req, line, line_id, input grant, done);
  modport arb (input req, line, line_id, output grant, done);
endinterface

`default_nettype wire

// ==== design/lfb_linefill_arb.sv ====
`default_nettype none

module lfb_linefill_arb #(
  parameter int NUM_ENTRIES = 2
) (
  input  wire                      lfb_data_entry_clk,
  input  wire                      cpurst_b,
  lfb_lf_if.arb                    lf,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output lfb_bus_pkg::wb_adr_t     wb_adr,
  input  wire                      wb_ack,
  output lfb_geom_pkg::beat_t      wb_wdata
);
  import lfb_geom_pkg::*;
  import lfb_bus_pkg::*;

  localparam int    IDX_W     = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
  localparam int    BW        = $bits(beat_t);
  localparam slot_t LAST_SLOT = slot_t'(BEATS_PER_LINE - 1);

  logic [NUM_ENTRIES-1:0] grant_q;
  logic [NUM_ENTRIES-1:0] done_q;
  logic [IDX_W-1:0]       gnt_idx_q;
  logic [IDX_W-1:0]       last_q;
  logic [IDX_W-1:0]       win_idx;
  logic [IDX_W-1:0]       src_idx;
  logic                   win_vld;
  logic                   active;
  logic                   word_ack;
  logic                   last_ack;
  slot_t                  slot_q;
  slot_t                  src_slot;
  line_t                  src_line;

  assign active   = |grant_q;
  assign word_ack = wb_cyc && wb_ack;
  assign last_ack = word_ack && (slot_q == LAST_SLOT);

  // ==============================
  // round robin pick
  // ==============================
  // search starts just after the last winner
  always_comb
  begin
    int j;
    win_vld = 1'b0;
    win_idx = '0;
    for (int k = 1; k <= NUM_ENTRIES; k++)
    begin
      j = int'(last_q) + k;
      if (j >= NUM_ENTRIES)
        j = j - NUM_ENTRIES;
      if (!win_vld && lf.req[j])
      begin
        win_vld = 1'b1;
        win_idx = IDX_W'(j);
      end
    end
  end

  // next word is slot 0 of the winner or the following slot
  assign src_idx  = active ? gnt_idx_q : win_idx;
  assign src_slot = active ? slot_q + 2'd1 : '0;
  assign src_line = lf.line[src_idx];

  // ==============================
  // wishbone write sequencer
  // ==============================
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      grant_q   <= '0;
      done_q    <= '0;
      gnt_idx_q <= '0;
      last_q    <= IDX_W'(NUM_ENTRIES - 1);
      slot_q    <= '0;
      wb_cyc    <= 1'b0;
      wb_adr    <= '0;
      wb_wdata  <= '0;
    end
    else
    begin
      done_q <= '0;
      if (!active)
      begin
        if (win_vld)
        begin
          grant_q   <= NUM_ENTRIES'(1) << win_idx;
          gnt_idx_q <= win_idx;
          last_q    <= win_idx;
          slot_q    <= '0;
          wb_cyc    <= 1'b1;
          wb_adr    <= {lf.line_id[src_idx], src_slot};
          wb_wdata  <= src_line[src_slot*BW +: BW];
        end
      end
      else if (last_ack)
      begin
        grant_q <= '0;
        done_q  <= grant_q;
        wb_cyc  <= 1'b0;
      end
      else if (word_ack)
      begin
        // one dead cycle between words
        wb_cyc   <= 1'b0;
        slot_q   <= src_slot;
        wb_adr   <= {lf.line_id[src_idx], src_slot};
        wb_wdata <= src_line[src_slot*BW +: BW];
      end
      else if (!wb_cyc)
      begin
        wb_cyc <= 1'b1;
      end
    end
  end

  assign wb_stb   = wb_cyc;
  assign wb_we    = wb_cyc;
  assign lf.grant = grant_q;
  assign lf.done  = done_q;

  // the line under write stays put until the fourth ack
  a_grant_hold: assert property (
    @(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    (active && !last_ack) |=> $stable(src_line)
  );

  // the granted entry drops its request one cycle after the grant
  a_grant_req: assert property (
    @(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    (active && $past(active)) |-> !(|(lf.req & grant_q))
  );

endmodule

`default_nettype wire

// ==== design/lfb_top.sv ====
`default_nettype none

module lfb_top #(
  parameter int NUM_ENTRIES = 2
) (
  input  wire                      lfb_data_entry_clk,
  input  wire                      cpurst_b,
  input  wire                      r_vld,
  input  wire lfb_bus_pkg::id_t    r_id,
  input  wire lfb_geom_pkg::beat_t r_data,
  input  wire                      r_last,
  input  wire                      r_err,
  input  wire lfb_geom_pkg::slot_t r_ptr,
  input  wire                      dcache_en,
  output logic                     r_ready,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output lfb_bus_pkg::wb_adr_t     wb_adr,
  input  wire                      wb_ack,
  output lfb_geom_pkg::beat_t      wb_wdata
);

  lfb_fill_if #(.NUM_ENTRIES(NUM_ENTRIES)) u_fill_if ();
  lfb_lf_if   #(.NUM_ENTRIES(NUM_ENTRIES)) u_lf_if ();

  // ==============================
  // beat router
  // ==============================
  lfb_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) u_alloc (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .r_vld              (r_vld),
    .r_id               (r_id),
    .r_data             (r_data),
    .r_last             (r_last),
    .r_err              (r_err),
    .r_ptr              (r_ptr),
    .r_ready            (r_ready),
    .fill               (u_fill_if.alloc)
  );

  // fill entries
  for (genvar gi = 0; gi < NUM_ENTRIES; gi++)
  begin : g_entry
    lfb_data_entry #(.ENTRY_IDX(gi)) u_entry (
      .lfb_data_entry_clk (lfb_data_entry_clk),
      .cpurst_b           (cpurst_b),
      .dcache_en          (dcache_en),
      .fill               (u_fill_if.entry),
      .lf                 (u_lf_if.entry)
    );
  end

  // ==============================
  // linefill write port
  // ==============================
  lfb_linefill_arb #(.NUM_ENTRIES(NUM_ENTRIES)) u_arb (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .lf                 (u_lf_if.arb),
    .wb_cyc             (wb_cyc),
    .wb_stb             (wb_stb),
    .wb_we              (wb_we),
    .wb_adr             (wb_adr),
    .wb_ack             (wb_ack),
    .wb_wdata           (wb_wdata)
  );

endmodule

`default_nettype wire

// ==== src.f ====
design/lfb_geom_pkg.sv
design/lfb_bus_pkg.sv
design/lfb_if.sv
design/lfb_alloc.sv
design/lfb_data_entry.sv
design/lfb_linefill_arb.sv
design/lfb_top.sv
test/lfb_clk_gen.sv
test/lfb_tb.sv

// ==== test/lfb_clk_gen.sv ====
`default_nettype none

module lfb_clk_gen (
  output logic lfb_data_entry_clk,
  output logic cpurst_b
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 16;

  initial
  begin
    lfb_data_entry_clk = 1'b0;
    forever
      #HALF_PERIOD lfb_data_entry_clk = ~lfb_data_entry_clk;
  end

  // reset released just after an edge
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge lfb_data_entry_clk);
    #1;
    cpurst_b = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/lfb_tb.sv ====
`default_nettype none

module lfb_tb;
  import lfb_geom_pkg::*;
  import lfb_bus_pkg::*;

  localparam int          NUM_ENTRIES     = 2;
  localparam int          TEST_LINES      = 13;
  localparam int          WATCHDOG_CYCLES = 200 * TEST_LINES + 500;
  localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

  logic    lfb_data_entry_clk;
  logic    cpurst_b;
  logic    r_vld;
  id_t     r_id;
  beat_t   r_data;
  logic    r_last;
  logic    r_err;
  slot_t   r_ptr;
  logic    dcache_en;
  logic    r_ready;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  wb_adr_t wb_adr;
  logic    wb_ack;
  beat_t   wb_wdata;

  // one random stream for stimulus, one for the ack delays
  logic [31:0] stim_lfsr = 32'd39;
  logic [31:0] ack_lfsr  = 32'd39;

  logic    ack_en;
  line_t   exp_line [8];
  logic    exp_pending [8];
  slot_t   next_slot [8];
  int      lines_expected;
  int      lines_done;
  wb_adr_t q_adr [$];
  beat_t   q_data [$];

  lfb_clk_gen u_clk_gen (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b)
  );

  lfb_top #(.NUM_ENTRIES(NUM_ENTRIES)) u_lfb_top (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .r_vld              (r_vld),
    .r_id               (r_id),
    .r_data             (r_data),
    .r_last             (r_last),
    .r_err              (r_err),
    .r_ptr              (r_ptr),
    .dcache_en          (dcache_en),
    .r_ready            (r_ready),
    .wb_cyc             (wb_cyc),
    .wb_stb             (wb_stb),
    .wb_we              (wb_we),
    .wb_adr             (wb_adr),
    .wb_ack             (wb_ack),
    .wb_wdata           (wb_wdata)
  );

  // ==============================
  // random numbers and reference
  // ==============================
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0])
      nxt = nxt ^ LFSR_TAPS;
    return nxt;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n,
                           output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val   = {val[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  // critical word lands at ptr, later beats wrap through the slots
  function automatic line_t ref_line(input beat_t beats [4], input slot_t ptr);
    line_t result;
    slot_t slot;
    result = '0;
    for (int i = 0; i < 4; i++)
    begin
      slot = ptr + slot_t'(i);
      result[slot*32 +: 32] = beats[i];
    end
    return result;
  endfunction

  task automatic halt_on_error();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
      halt_on_error();
    end
  endtask

  // ==============================
  // stimulus helpers
  // ==============================
  task automatic tick();
    @(posedge lfb_data_entry_clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) tick();
  endtask

  task automatic drive_beat(input id_t id, input beat_t data, input logic last,
                            input logic err, input slot_t ptr);
    r_vld  = 1'b1;
    r_id   = id;
    r_data = data;
    r_last = last;
    r_err  = err;
    r_ptr  = ptr;
  endtask

  // ready is sampled mid cycle, the beat is taken on the next edge
  task automatic wait_accept();
    logic rdy;
    rdy = 1'b0;
    while (!rdy)
    begin
      @(negedge lfb_data_entry_clk);
      rdy = r_ready;
      tick();
    end
    r_vld = 1'b0;
  endtask

  task automatic send_beat(input id_t id, input beat_t data, input logic last,
                           input logic err, input slot_t ptr);
    drive_beat(id, data, last, err, ptr);
    wait_accept();
  endtask

  task automatic random_beats(output beat_t beats [4]);
    logic [31:0] r;
    for (int i = 0; i < 4; i++)
    begin
      draw_bits(stim_lfsr, 32, r);
      beats[i] = r;
    end
  endtask

  task automatic expect_line(input id_t id, input slot_t ptr, input beat_t beats [4]);
    exp_line[id]    = ref_line(beats, ptr);
    exp_pending[id] = 1'b1;
    next_slot[id]   = '0;
    lines_expected++;
  endtask

  // err_beat outside 0..3 sends a clean line
  task automatic send_line(input id_t id, input slot_t ptr, input int err_beat,
                           input logic expect_write);
    beat_t beats [4];
    random_beats(beats);
    if (expect_write)
      expect_line(id, ptr, beats);
    for (int i = 0; i < 4; i++)
      send_beat(id, beats[i], (i == 3), (i == err_beat), ptr);
  endtask

  task automatic wait_lines_done();
    while (lines_done != lines_expected)
      tick();
  endtask

  // ==============================
  // wishbone responder and compare
  // ==============================
  initial
  begin : wb_responder
    logic        pending;
    logic [31:0] wait_cnt;
    wb_ack   = 1'b0;
    pending  = 1'b0;
    wait_cnt = '0;
    forever
    begin
      tick();
      wb_ack = 1'b0;
      if (cpurst_b && wb_cyc)
      begin
        check_value("wb_stb", 1'b1, wb_stb);
        check_value("wb_we", 1'b1, wb_we);
        // new word, pick 0 to 3 wait cycles
        if (!pending)
        begin
          draw_bits(ack_lfsr, 2, wait_cnt);
          pending = 1'b1;
        end
        if (ack_en)
        begin
          if (wait_cnt == 0)
          begin
            wb_ack  = 1'b1;
            pending = 1'b0;
            q_adr.push_back(wb_adr);
            q_data.push_back(wb_wdata);
          end
          else
            wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

  initial
  begin : wb_compare
    wb_adr_t adr;
    beat_t   data;
    id_t     id;
    slot_t   slot;
    forever
    begin
      @(negedge lfb_data_entry_clk);
      while (q_adr.size() > 0)
      begin
        adr  = q_adr.pop_front();
        data = q_data.pop_front();
        {id, slot} = adr;
        if (!exp_pending[id])
        begin
          $display("unexpected write to address %0h at time %0t", adr, $time);
          halt_on_error();
        end
        check_value("wb_adr slot", next_slot[id], slot);
        check_value("wb_wdata", exp_line[id][slot*32 +: 32], data);
        next_slot[id] = slot + 2'd1;
        if (slot == 2'd3)
        begin
          exp_pending[id] = 1'b0;
          lines_done++;
        end
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge lfb_data_entry_clk);
    $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    halt_on_error();
  end

  // ==============================
  // test sequence
  // ==============================
  initial
  begin : stimulus
    beat_t       beats_a [4];
    beat_t       beats_b [4];
    slot_t       ptr_a;
    slot_t       ptr_b;
    logic [31:0] r;

    r_vld          = 1'b0;
    r_id           = '0;
    r_data         = '0;
    r_last         = 1'b0;
    r_err          = 1'b0;
    r_ptr          = '0;
    dcache_en      = 1'b1;
    ack_en         = 1'b1;
    lines_expected = 0;
    lines_done     = 0;
    for (int i = 0; i < 8; i++)
    begin
      exp_line[i]    = '0;
      exp_pending[i] = 1'b0;
      next_slot[i]   = '0;
    end

    @(posedge cpurst_b);
    tick();
    @(negedge lfb_data_entry_clk);
    check_value("r_ready", 1'b1, r_ready);
    check_value("wb_cyc", 1'b0, wb_cyc);
    tick();

    // pointer 0, write starts two cycles after the last beat
    send_line(3'd1, 2'd0, -1, 1'b1);
    @(negedge lfb_data_entry_clk);
    check_value("wb_cyc", 1'b0, wb_cyc);
    tick();
    @(negedge lfb_data_entry_clk);
    check_value("wb_cyc", 1'b1, wb_cyc);
    tick();
    wait_lines_done();

    // rotated lines
    for (int p = 1; p < 4; p++)
    begin
      send_line(id_t'(p + 1), slot_t'(p), -1, 1'b1);
      wait_lines_done();
    end

    // two ids interleaved beat by beat
    random_beats(beats_a);
    random_beats(beats_b);
    draw_bits(stim_lfsr, 2, r);
    ptr_a = r[1:0];
    draw_bits(stim_lfsr, 2, r);
    ptr_b = r[1:0];
    expect_line(3'd5, ptr_a, beats_a);
    expect_line(3'd6, ptr_b, beats_b);
    for (int i = 0; i < 4; i++)
    begin
      send_beat(3'd5, beats_a[i], (i == 3), 1'b0, ptr_a);
      send_beat(3'd6, beats_b[i], (i == 3), 1'b0, ptr_b);
    end
    wait_lines_done();

    // ==============================
    // aborted lines, then the same id again
    // ==============================
    draw_bits(stim_lfsr, 32, r);
    send_beat(3'd7, r, 1'b1, 1'b0, 2'd0);
    idle_cycles(20);
    draw_bits(stim_lfsr, 2, r);
    send_line(3'd7, 2'd1, int'(r[1:0]), 1'b0);
    idle_cycles(20);
    dcache_en = 1'b0;
    send_line(3'd7, 2'd2, -1, 1'b0);
    dcache_en = 1'b1;
    idle_cycles(20);
    draw_bits(stim_lfsr, 2, r);
    send_line(3'd7, r[1:0], -1, 1'b1);
    wait_lines_done();

    // ack held off, third id waits for a free entry
    @(negedge lfb_data_entry_clk);
    ack_en = 1'b0;
    tick();
    draw_bits(stim_lfsr, 2, r);
    send_line(3'd1, r[1:0], -1, 1'b1);
    draw_bits(stim_lfsr, 2, r);
    send_line(3'd2, r[1:0], -1, 1'b1);
    random_beats(beats_a);
    draw_bits(stim_lfsr, 2, r);
    ptr_a = r[1:0];
    expect_line(3'd3, ptr_a, beats_a);
    drive_beat(3'd3, beats_a[0], 1'b0, 1'b0, ptr_a);
    repeat (4)
    begin
      @(negedge lfb_data_entry_clk);
      check_value("r_ready", 1'b0, r_ready);
      tick();
    end
    @(negedge lfb_data_entry_clk);
    ack_en = 1'b1;
    wait_accept();
    for (int i = 1; i < 4; i++)
      send_beat(3'd3, beats_a[i], (i == 3), 1'b0, ptr_a);
    wait_lines_done();

    idle_cycles(10);
    if (lines_done != lines_expected || q_adr.size() != 0)
    begin
      $display("only %0d of %0d lines were written", lines_done, lines_expected);
      halt_on_error();
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
